//--- dv/tb_clk_gen.sv
// ======================================================================
// testbench clock and reset
// 40 ns clock, active-low reset held for the first four rising edges
// ======================================================================
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // released on a rising edge, so that edge still sees reset
    initial begin
        reset_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b1;
    end

endmodule

//--- dv/tb_des.sv
// ======================================================================
// DES core testbench
// directed tests: reset, FIPS known answers, random round trip and
// output back-pressure
// ======================================================================
`timescale 1ns/1ps

module tb_des;

    localparam int LATENCY     = 17;
    localparam int WAIT_LIMIT  = 100;
    localparam int HOLD_CYCLES = 10;
    localparam int NUM_RANDOM  = 8;

    localparam logic [63:0] KAT_KEY = 64'h1334_5779_9BBC_DFF1;
    localparam logic [63:0] KAT_PT  = 64'h0123_4567_89AB_CDEF;
    localparam logic [63:0] KAT_CT  = 64'h85E8_1354_0F0A_B405;
    localparam logic [63:0] ZERO_CT = 64'h8CA6_4DE9_C1B1_23A7;

    logic        clk_i;
    logic        reset_i;
    logic        mode_i;
    logic [63:0] key_i;
    logic [63:0] data_i;
    logic        valid_i;
    logic        accept_i;
    logic        accept_o;
    logic        valid_o;
    logic [63:0] data_o;

    integer seed;
    int     error_count;
    int     test_count;
    int     failed_tests;
    int     errors_at_start;
    string  current_test;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk_i),
        .reset_o (reset_i)
    );

    des_core u_dut (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .mode_i   (mode_i),
        .key_i    (key_i),
        .data_i   (data_i),
        .valid_i  (valid_i),
        .accept_i (accept_i),
        .accept_o (accept_o),
        .valid_o  (valid_o),
        .data_o   (data_o)
    );

    // ==================================================================
    // reporting
    // ==================================================================
    task automatic value_mismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] expected);
        $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                 $time, what, got, expected);
        error_count++;
    endtask

    task automatic flag_mismatch(input string what, input logic got, input logic expected);
        $display("CHECK FAILED at %0t ns: %s, got %b, expected %b",
                 $time, what, got, expected);
        error_count++;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t ns: %s did not happen in %0d cycles",
                 $time, what, WAIT_LIMIT);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic start_test(input string name);
        current_test    = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test;
        test_count++;
        if (error_count == errors_at_start) begin
            $display("test %s: pass", current_test);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", current_test, error_count - errors_at_start);
        end
    endtask

    // ==================================================================
    // handshake helpers
    // ==================================================================
    // returns right after the edge that takes the block
    task automatic send_block(input logic mode, input logic [63:0] key,
                              input logic [63:0] data);
        int waited;
        waited = 0;
        @(posedge clk_i);
        mode_i  <= mode;
        key_i   <= key;
        data_i  <= data;
        valid_i <= 1'b1;
        @(negedge clk_i);
        while (!accept_o) begin
            if (waited >= WAIT_LIMIT) stop_on_timeout("accept_o");
            @(negedge clk_i);
            waited++;
        end
        @(posedge clk_i);
        valid_i <= 1'b0;
    endtask

    // cycles counts rising edges since the accept edge
    task automatic wait_result(output logic [63:0] result, output int cycles);
        cycles = 0;
        @(negedge clk_i);
        while (!valid_o) begin
            if (cycles >= WAIT_LIMIT) stop_on_timeout("valid_o");
            @(negedge clk_i);
            cycles++;
        end
        result = data_o;
    endtask

    task automatic wait_release;
        int waited;
        waited = 0;
        while (valid_o) begin
            if (waited >= WAIT_LIMIT) stop_on_timeout("valid_o to fall");
            @(negedge clk_i);
            waited++;
        end
    endtask

    task automatic run_block(input logic mode, input logic [63:0] key,
                             input logic [63:0] data, output logic [63:0] result);
        int cycles;
        send_block(mode, key, data);
        wait_result(result, cycles);
        if (cycles != LATENCY) value_mismatch("latency", 64'(cycles), 64'(LATENCY));
        wait_release();
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================
    task automatic expect_reset_state;
        int waited;
        waited = 0;
        start_test("reset");
        @(negedge clk_i);
        while (!reset_i) begin
            if (accept_o !== 1'b0) flag_mismatch("accept_o in reset", accept_o, 1'b0);
            if (valid_o !== 1'b0) flag_mismatch("valid_o in reset", valid_o, 1'b0);
            if (data_o !== 64'h0) value_mismatch("data_o in reset", data_o, 64'h0);
            if (waited >= WAIT_LIMIT) stop_on_timeout("reset release");
            @(negedge clk_i);
            waited++;
        end
        // value seen by the first edge after release
        if (accept_o !== 1'b0) flag_mismatch("accept_o at first edge", accept_o, 1'b0);
        if (valid_o !== 1'b0) flag_mismatch("valid_o at first edge", valid_o, 1'b0);
        @(negedge clk_i);
        if (accept_o !== 1'b1) flag_mismatch("accept_o at second edge", accept_o, 1'b1);
        if (valid_o !== 1'b0) flag_mismatch("valid_o at second edge", valid_o, 1'b0);
        finish_test();
    endtask

    task automatic encrypt_fips_vectors;
        logic [63:0] result;
        start_test("kat_encrypt");
        run_block(1'b0, KAT_KEY, KAT_PT, result);
        if (result !== KAT_CT) value_mismatch("encrypt fips vector", result, KAT_CT);
        run_block(1'b0, 64'h0, 64'h0, result);
        if (result !== ZERO_CT) value_mismatch("encrypt zero key", result, ZERO_CT);
        finish_test();
    endtask

    task automatic decrypt_fips_vector;
        logic [63:0] result;
        start_test("kat_decrypt");
        run_block(1'b1, KAT_KEY, KAT_CT, result);
        if (result !== KAT_PT) value_mismatch("decrypt fips vector", result, KAT_PT);
        finish_test();
    endtask

    task automatic round_trip_random;
        logic [63:0] key;
        logic [63:0] plain;
        logic [63:0] cipher;
        logic [63:0] back;
        start_test("round_trip");
        for (int i = 0; i < NUM_RANDOM; i++) begin
            key   = {$random(seed), $random(seed)};
            plain = {$random(seed), $random(seed)};
            run_block(1'b0, key, plain, cipher);
            run_block(1'b1, key, cipher, back);
            if (back !== plain) value_mismatch("round trip plaintext", back, plain);
        end
        finish_test();
    endtask

    task automatic hold_under_back_pressure;
        logic [63:0] held;
        int          cycles;
        start_test("back_pressure");
        @(posedge clk_i);
        accept_i <= 1'b0;
        send_block(1'b0, KAT_KEY, KAT_PT);
        wait_result(held, cycles);
        if (cycles != LATENCY) value_mismatch("latency", 64'(cycles), 64'(LATENCY));
        if (held !== KAT_CT) value_mismatch("held result", held, KAT_CT);
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk_i);
            if (valid_o !== 1'b1) flag_mismatch("valid_o while stalled", valid_o, 1'b1);
            if (data_o !== held) value_mismatch("data_o while stalled", data_o, held);
            if (accept_o !== 1'b0) flag_mismatch("accept_o while stalled", accept_o, 1'b0);
        end
        @(posedge clk_i);
        accept_i <= 1'b1;
        @(negedge clk_i);
        if (valid_o !== 1'b1) flag_mismatch("valid_o before accept seen", valid_o, 1'b1);
        @(negedge clk_i);
        if (valid_o !== 1'b0) flag_mismatch("valid_o after accept", valid_o, 1'b0);
        if (accept_o !== 1'b0) flag_mismatch("accept_o after accept", accept_o, 1'b0);
        @(negedge clk_i);
        if (accept_o !== 1'b1) flag_mismatch("accept_o one cycle later", accept_o, 1'b1);
        finish_test();
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        seed         = 32'he0879a95;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        mode_i       = 1'b0;
        key_i        = 64'h0;
        data_i       = 64'h0;
        valid_i      = 1'b0;
        accept_i     = 1'b1;

        expect_reset_state();
        encrypt_fips_vectors();
        decrypt_fips_vector();
        round_trip_random();
        hold_under_back_pressure();

        $display("tests run %0d, tests with errors %0d, check errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hw/des_core.sv
// ======================================================================
// DES core
// iterative engine, one round per clock, valid/accept on both sides
// ======================================================================
`timescale 1ns/1ps

module des_core
    import des_pkg::*;
(
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               mode_i,
    input  logic [KEY_W-1:0]   key_i,
    input  logic [BLOCK_W-1:0] data_i,
    input  logic               valid_i,
    input  logic               accept_i,
    output logic               accept_o,
    output logic               valid_o,
    output block_t             data_o
);

    des_step_if step_bus ();

    // ==================================================================
    // sequencer
    // ==================================================================
    des_ctrl u_ctrl (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .mode_i   (mode_i),
        .valid_i  (valid_i),
        .accept_i (accept_i),
        .accept_o (accept_o),
        .valid_o  (valid_o),
        .step     (step_bus.ctrl)
    );

    // ==================================================================
    // key schedule and data rounds
    // ==================================================================
    des_key_sched u_key_sched (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .key_i   (key_i),
        .step    (step_bus.sched)
    );

    des_round u_round (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (data_i),
        .data_o  (data_o),
        .step    (step_bus.round)
    );

endmodule

//--- hw/des_ctrl.sv
// ======================================================================
// DES round sequencer
// input/output handshake, round counter and per-block mode
// ======================================================================
`timescale 1ns/1ps

module des_ctrl
    import des_pkg::*;
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic mode_i,
    input  logic valid_i,
    input  logic accept_i,
    output logic accept_o,
    output logic valid_o,
    des_step_if.ctrl step
);

    round_t round_q;
    logic   mode_q;

    assign step.load      = (round_q == ROUND_IDLE) && valid_i && accept_o;
    assign step.step      = (round_q != ROUND_IDLE) && (round_q <= round_t'(NUM_ROUNDS));
    assign step.round_idx = round_q;
    assign step.mode      = mode_q;

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            round_q  <= ROUND_IDLE;
            mode_q   <= 1'b0;
            accept_o <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            case (round_q)
                ROUND_IDLE: begin
                    accept_o <= 1'b1;
                    if (step.load) begin
                        accept_o <= 1'b0;
                        mode_q   <= mode_i;
                        round_q  <= 5'd1;
                    end
                end
                // result sits here until the sink takes it
                ROUND_DONE: begin
                    valid_o <= 1'b1;
                    if (valid_o && accept_i) begin
                        valid_o <= 1'b0;
                        round_q <= ROUND_IDLE;
                    end
                end
                default: begin
                    round_q <= round_q + 5'd1;
                end
            endcase
        end
    end

endmodule

//--- hw/des_f_func.sv
// ======================================================================
// DES Feistel function
// expansion, key mix, S-box substitution and P permutation
// ======================================================================
`timescale 1ns/1ps

module des_f_func
    import des_pkg::*;
(
    input  half_t   r_i,
    input  subkey_t key_i,
    output half_t   f_o
);

    subkey_t mixed;
    half_t   subst;

    // 32 -> 48 bits, then key mix
    assign mixed = e_expand(r_i) ^ key_i;

    // eight 6-to-4 lookups
    assign subst = sbox_sub(mixed);

    assign f_o = p_perm(subst);

endmodule

//--- hw/des_key_sched.sv
// ======================================================================
// DES key schedule
// C/D halves rotated once per round, PC-2 gives the round key
// ======================================================================
`timescale 1ns/1ps

module des_key_sched
    import des_pkg::*;
(
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic [KEY_W-1:0] key_i,
    des_step_if.sched        step
);

    cd_t    c_q;
    cd_t    d_q;
    cd_t    c_use;
    cd_t    d_use;
    round_t dec_idx;

    // decryption walks the shift table backwards
    assign dec_idx = ROUND_DONE + 5'd1 - step.round_idx;

    always_comb begin
        c_use = c_q;
        d_use = d_q;
        if (step.step) begin
            if (!step.mode) begin
                c_use = rot_left(c_q, KEY_SHIFT[step.round_idx]);
                d_use = rot_left(d_q, KEY_SHIFT[step.round_idx]);
            end else if (step.round_idx != 5'd1) begin
                // round 1 of decrypt uses C16/D16, which equal C0/D0
                c_use = rot_right(c_q, KEY_SHIFT[dec_idx]);
                d_use = rot_right(d_q, KEY_SHIFT[dec_idx]);
            end
        end
    end

    assign step.round_key = pc2_perm(c_use, d_use);

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            c_q <= '0;
            d_q <= '0;
        end else if (step.load) begin
            c_q <= pc1_c(key_i);
            d_q <= pc1_d(key_i);
        end else if (step.step) begin
            c_q <= c_use;
            d_q <= d_use;
        end
    end

endmodule

//--- hw/des_pkg.sv
// ======================================================================
// DES package
// widths, round indices, FIPS 46-3 tables and the bit helpers shared
// by the sequencer, key schedule and round datapath
// ======================================================================
package des_pkg;

    localparam int BLOCK_W    = 64;
    localparam int HALF_W     = 32;
    localparam int KEY_W      = 64;
    localparam int CD_W       = 28;
    localparam int SUBKEY_W   = 48;
    localparam int NUM_ROUNDS = 16;

    typedef logic [BLOCK_W-1:0]  block_t;
    typedef logic [HALF_W-1:0]   half_t;
    typedef logic [CD_W-1:0]     cd_t;
    typedef logic [SUBKEY_W-1:0] subkey_t;
    // 0 idle, 1..16 rounds, 17 done
    typedef logic [4:0]          round_t;

    localparam round_t ROUND_IDLE = 5'd0;
    localparam round_t ROUND_DONE = round_t'(NUM_ROUNDS + 1);

    // left rotation per round
    localparam int KEY_SHIFT [1:16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // ==================================================================
    // permutation tables, 1-based with bit 1 as the MSB
    // ==================================================================
    localparam int IP [BLOCK_W] = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7};

    localparam int IP_INV [BLOCK_W] = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25};

    localparam int E [SUBKEY_W] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1};

    localparam int P [HALF_W] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25};

    // first 28 entries select C, the rest select D
    localparam int PC1 [2*CD_W] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4};

    localparam int PC2 [SUBKEY_W] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
        26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

    // one line per S-box row, index is row*16 + column
    localparam int SBOX [8][64] = '{
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}};

    // ==================================================================
    // bit helpers
    // ==================================================================
    function automatic block_t ip_perm(input block_t x);
        block_t y;
        for (int i = 0; i < BLOCK_W; i++) begin
            y[BLOCK_W-1-i] = x[BLOCK_W-IP[i]];
        end
        return y;
    endfunction

    function automatic block_t ip_inv_perm(input block_t x);
        block_t y;
        for (int i = 0; i < BLOCK_W; i++) begin
            y[BLOCK_W-1-i] = x[BLOCK_W-IP_INV[i]];
        end
        return y;
    endfunction

    // parity bits of the key drop out here
    function automatic cd_t pc1_c(input logic [KEY_W-1:0] k);
        cd_t y;
        for (int i = 0; i < CD_W; i++) begin
            y[CD_W-1-i] = k[KEY_W-PC1[i]];
        end
        return y;
    endfunction

    function automatic cd_t pc1_d(input logic [KEY_W-1:0] k);
        cd_t y;
        for (int i = 0; i < CD_W; i++) begin
            y[CD_W-1-i] = k[KEY_W-PC1[CD_W+i]];
        end
        return y;
    endfunction

    function automatic subkey_t pc2_perm(input cd_t c, input cd_t d);
        logic [2*CD_W-1:0] cd;
        subkey_t y;
        cd = {c, d};
        for (int i = 0; i < SUBKEY_W; i++) begin
            y[SUBKEY_W-1-i] = cd[2*CD_W-PC2[i]];
        end
        return y;
    endfunction

    function automatic subkey_t e_expand(input half_t r);
        subkey_t y;
        for (int i = 0; i < SUBKEY_W; i++) begin
            y[SUBKEY_W-1-i] = r[HALF_W-E[i]];
        end
        return y;
    endfunction

    function automatic half_t p_perm(input half_t x);
        half_t y;
        for (int i = 0; i < HALF_W; i++) begin
            y[HALF_W-1-i] = x[HALF_W-P[i]];
        end
        return y;
    endfunction

    // row from the outer bits, column from the inner four
    function automatic half_t sbox_sub(input subkey_t x);
        half_t y;
        logic [5:0] six;
        for (int b = 0; b < 8; b++) begin
            six = x[SUBKEY_W-1-6*b -: 6];
            y[HALF_W-1-4*b -: 4] = 4'(SBOX[b][{six[5], six[0], six[4:1]}]);
        end
        return y;
    endfunction

    function automatic cd_t rot_left(input cd_t x, input int unsigned n);
        return (x << n) | (x >> (CD_W - n));
    endfunction

    function automatic cd_t rot_right(input cd_t x, input int unsigned n);
        return (x >> n) | (x << (CD_W - n));
    endfunction

endpackage

//--- hw/des_round.sv
// ======================================================================
// DES round datapath
// L/R registers, one Feistel round per step, final permutation output
// ======================================================================
`timescale 1ns/1ps

module des_round
    import des_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset_i,
    input  block_t data_i,
    output block_t data_o,
    des_step_if.round step
);

    half_t  l_q;
    half_t  r_q;
    half_t  f_val;
    block_t ip_val;

    assign ip_val = ip_perm(data_i);

    des_f_func u_f_func (
        .r_i   (r_q),
        .key_i (step.round_key),
        .f_o   (f_val)
    );

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            l_q    <= '0;
            r_q    <= '0;
            data_o <= '0;
        end else if (step.load) begin
            l_q <= ip_val[BLOCK_W-1:HALF_W];
            r_q <= ip_val[HALF_W-1:0];
        end else if (step.step) begin
            l_q <= r_q;
            r_q <= l_q ^ f_val;
        end else if (step.round_idx == ROUND_DONE) begin
            // halves swap back before IP^-1
            data_o <= ip_inv_perm({r_q, l_q});
        end
    end

endmodule

//--- hw/des_step_if.sv
// ======================================================================
// DES step bus
// round control from the sequencer and the round key back to the data
// ======================================================================
`timescale 1ns/1ps

interface des_step_if;

    // one cycle when a block is taken
    logic        load;
    // high in rounds 1 to 16
    logic        step;
    logic [4:0]  round_idx;
    // 0 encrypt, 1 decrypt
    logic        mode;
    logic [47:0] round_key;

    modport ctrl  (output load, step, round_idx, mode);
    modport sched (input load, step, round_idx, mode, output round_key);
    modport round (input load, step, round_idx, round_key);

endinterface

//--- list.f
hw/des_pkg.sv
hw/des_step_if.sv
hw/des_f_func.sv
hw/des_ctrl.sv
hw/des_key_sched.sv
hw/des_round.sv
hw/des_core.sv
dv/tb_clk_gen.sv
dv/tb_des.sv

//--- run.sh
#!/bin/sh
# build and run the DES core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_des \
    -Mdir obj_dir -o sim_des
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_des > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
